/* flist.f */
+incdir+.
rx_intf_pkg.sv
rx_sample_sel.sv
byte_to_word_packer.sv
rx_pkt_framer.sv
rx_stream_fifo.sv
rx_intf.sv
rx_intf_checker.sv
tb_rx_intf.sv

/* Bender.yml */
package:
  name: rx_intf

sources:
  - include_dirs:
      - .
    files:
      - rx_intf_pkg.sv
      - rx_sample_sel.sv
      - byte_to_word_packer.sv
      - rx_pkt_framer.sv
      - rx_stream_fifo.sv
      - rx_intf.sv
  - target: test
    include_dirs:
      - .
    files:
      - rx_intf_checker.sv
      - tb_rx_intf.sv

/* tb_rx_intf.sv */
// testbench top with clock, reset, seeded random stimulus, timeout and final report
`timescale 1ns/1ps
`include "rx_intf_settings.svh"

module tb_rx_intf
    import rx_intf_pkg::*;
();

    // 40 packets of up to 300 cycles, plus margin
    localparam int MAX_CYCLES = 40 * 300 + 3000;

    logic         clk;
    logic         reset;
    rx_cfg_t      cfg;
    ant_pair_t    adc_data;
    logic         adc_valid;
    iq_sample_t   iq0_from_tx_intf;
    iq_sample_t   iq1_from_tx_intf;
    logic         iq_valid_from_tx_intf;
    iq_sample_t   sample0;
    iq_sample_t   sample1;
    logic         sample_strobe;
    pkt_hdr_t     pkt_hdr;
    logic         pkt_header_valid;
    logic         pkt_header_valid_strobe;
    logic [7:0]   byte_in;
    logic         byte_in_strobe;
    logic         fcs_in_strobe;
    logic         fcs_ok;
    logic         m00_axis_tready;
    logic         m00_axis_tvalid;
    stream_word_t m00_axis_tdata;
    logic         m00_axis_tlast;
    logic         rx_pkt_intr;
    rx_sn_t       dropped_pkts;
    logic         end_of_test;
    int           pending_words;
    int           sample_errors;
    int           stream_errors;
    int           count_errors;
    int           cycle_cnt;
    // 0 random about 30 % high, 1 held low, 2 held high
    int           ready_mode;

    rx_intf dut0 (.*);

    rx_intf_checker chk0 (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    always @(posedge clk)
    begin
        #2;
        case (ready_mode)
            0: m00_axis_tready = (($urandom % 10) < 3);
            1: m00_axis_tready = 1'b0;
            default: m00_axis_tready = 1'b1;
        endcase
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // random samples on both paths under one cfg
    task automatic run_samples(input rx_cfg_t mode, input int n);
        cfg = mode;
        for (int i = 0; i < n; i++)
        begin
            adc_data              = ant_pair_t'({$urandom, $urandom});
            iq0_from_tx_intf      = iq_sample_t'($urandom);
            iq1_from_tx_intf      = iq_sample_t'($urandom);
            adc_valid             = $urandom % 2;
            iq_valid_from_tx_intf = $urandom % 2;
            step();
        end
        adc_valid             = 1'b0;
        iq_valid_from_tx_intf = 1'b0;
        step();
    endtask

    // header strobe, then the bytes and the FCS strobe as the decoder sends them
    task automatic send_packet(input int len, input logic hdr_valid);
        int nbytes;
        pkt_hdr.rate             = $urandom;
        pkt_hdr.len              = pkt_len_t'(len);
        pkt_hdr.ht_aggr          = $urandom % 2;
        pkt_hdr.ht_aggr_last     = $urandom % 2;
        pkt_hdr.ht_sgi           = $urandom % 2;
        pkt_hdr.ht_unsupport     = $urandom % 2;
        pkt_header_valid         = hdr_valid;
        pkt_header_valid_strobe  = 1'b1;
        step();
        pkt_header_valid_strobe  = 1'b0;
        pkt_header_valid         = 1'b0;
        if (hdr_valid)
        begin
            // oversize packets only get a short burst before the FCS
            nbytes = (len > `MAX_PKT_BYTES) ? 8 + $urandom % 8 : len;
            for (int i = 0; i < nbytes; i++)
            begin
                byte_in        = $urandom;
                byte_in_strobe = 1'b1;
                step();
            end
            byte_in_strobe = 1'b0;
            fcs_in_strobe  = 1'b1;
            fcs_ok         = $urandom % 2;
            step();
            fcs_in_strobe  = 1'b0;
        end
        repeat (6) step();
    endtask

    initial
    begin
        int seed_ret;
        int total;
        seed_ret                = $urandom(62);
        cycle_cnt               = 0;
        ready_mode              = 2;
        reset                   = 1'b1;
        cfg                     = '0;
        adc_data                = '0;
        adc_valid               = 1'b0;
        iq0_from_tx_intf        = '0;
        iq1_from_tx_intf        = '0;
        iq_valid_from_tx_intf   = 1'b0;
        pkt_hdr                 = '0;
        pkt_header_valid        = 1'b0;
        pkt_header_valid_strobe = 1'b0;
        byte_in                 = '0;
        byte_in_strobe          = 1'b0;
        fcs_in_strobe           = 1'b0;
        fcs_ok                  = 1'b0;
        m00_axis_tready         = 1'b1;
        end_of_test             = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        step();

        for (int c = 0; c < 8; c++)
        begin
            run_samples(rx_cfg_t'(c), 20);
        end
        cfg = '0;

        // framing, FCS bit and interrupts under random back-pressure
        ready_mode = 0;
        for (int i = 0; i < 20; i++)
        begin
            send_packet(1 + $urandom % `MAX_PKT_BYTES, 1'b1);
        end

        // oversize and invalid headers
        for (int i = 0; i < 3; i++)
        begin
            send_packet(`MAX_PKT_BYTES + 1 + $urandom % 200, 1'b1);
        end
        send_packet(1 + $urandom % `MAX_PKT_BYTES, 1'b0);
        send_packet(1 + $urandom % `MAX_PKT_BYTES, 1'b0);

        // stalled output until the FIFO runs out of room
        ready_mode = 1;
        for (int i = 0; i < 5; i++)
        begin
            send_packet(160 + $urandom % 97, 1'b1);
        end

        ready_mode = 2;
        while (pending_words != 0 || m00_axis_tvalid)
        begin
            step();
        end
        end_of_test = 1'b1;
        step();
        end_of_test = 1'b0;
        step();

        total = sample_errors + stream_errors + count_errors;
        $display("errors: sample %0d, stream %0d, count %0d, total %0d",
                 sample_errors, stream_errors, count_errors, total);
        if (total == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* rx_intf_checker.sv */
// testbench model and checks for samples, stream words, interrupts and drop count
`timescale 1ns/1ps
`include "rx_intf_settings.svh"

module rx_intf_checker
    import rx_intf_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  rx_cfg_t      cfg,
    input  ant_pair_t    adc_data,
    input  logic         adc_valid,
    input  iq_sample_t   iq0_from_tx_intf,
    input  iq_sample_t   iq1_from_tx_intf,
    input  logic         iq_valid_from_tx_intf,
    input  iq_sample_t   sample0,
    input  iq_sample_t   sample1,
    input  logic         sample_strobe,
    input  pkt_hdr_t     pkt_hdr,
    input  logic         pkt_header_valid,
    input  logic         pkt_header_valid_strobe,
    input  logic [7:0]   byte_in,
    input  logic         byte_in_strobe,
    input  logic         fcs_in_strobe,
    input  logic         fcs_ok,
    input  logic         m00_axis_tready,
    input  logic         m00_axis_tvalid,
    input  stream_word_t m00_axis_tdata,
    input  logic         m00_axis_tlast,
    input  logic         rx_pkt_intr,
    input  rx_sn_t       dropped_pkts,
    input  logic         end_of_test,
    output int           pending_words,
    output int           sample_errors,
    output int           stream_errors,
    output int           count_errors
);

    stream_word_t exp_data[$];
    logic         exp_last[$];
    logic         exp_strobe;
    iq_sample_t   exp_s0;
    iq_sample_t   exp_s1;
    logic         stall_q;
    stream_word_t held_data;
    logic         held_last;
    logic         pkt_open;
    stream_word_t acc;
    int           byte_idx;
    int           byte_cnt;
    int           words_written;
    int           xfer_count;
    int           drop_model;
    int           accepted;
    int           intr_seen;
    int           last_seen;

    initial
    begin
        sample_errors = 0;
        stream_errors = 0;
        count_errors  = 0;
        pending_words = 0;
    end

    task automatic push_word(input stream_word_t data, input logic last);
        exp_data.push_back(data);
        exp_last.push_back(last);
        words_written = words_written + 1;
    endtask

    // selected pair shows up one cycle after its valid
    task automatic check_samples();
        if (sample_strobe !== exp_strobe)
        begin
            sample_errors++;
            $display("error sample_sel strobe expected %0b actual %0b", exp_strobe, sample_strobe);
        end
        else if (exp_strobe && ({sample1, sample0} !== {exp_s1, exp_s0}))
        begin
            sample_errors++;
            $display("error sample_sel expected %h actual %h",
                     {exp_s1, exp_s0}, {sample1, sample0});
        end
        if (cfg.loopback_en)
        begin
            exp_strobe = iq_valid_from_tx_intf;
            exp_s0     = iq0_from_tx_intf;
            exp_s1     = iq1_from_tx_intf;
        end
        else
        begin
            exp_strobe = adc_valid;
            exp_s0     = cfg.ant_swap ? adc_data.ant1 : adc_data.ant0;
            exp_s1     = cfg.ant_swap ? adc_data.ant0 : adc_data.ant1;
            if (cfg.mute_ant0)
            begin
                exp_s0 = '0;
            end
        end
    endtask

    // accept rule against the modeled FIFO fill, then byte packing
    task automatic track_packets();
        int           need;
        int           occ;
        stream_word_t w;
        if (pkt_header_valid_strobe && pkt_header_valid && !pkt_open)
        begin
            need = (int'(pkt_hdr.len) + 7) / 8 + 2;
            occ  = words_written - xfer_count - (m00_axis_tvalid ? 1 : 0);
            if (int'(pkt_hdr.len) > `MAX_PKT_BYTES || need > `FIFO_DEPTH - occ)
            begin
                drop_model++;
            end
            else
            begin
                w         = '0;
                w[15:0]   = pkt_hdr.len;
                w[23:16]  = pkt_hdr.rate;
                w[24]     = pkt_hdr.ht_aggr;
                w[25]     = pkt_hdr.ht_aggr_last;
                w[26]     = pkt_hdr.ht_sgi;
                w[27]     = pkt_hdr.ht_unsupport;
                w[47:32]  = rx_sn_t'(accepted);
                push_word(w, 1'b0);
                pkt_open = 1'b1;
                acc      = '0;
                byte_idx = 0;
                byte_cnt = 0;
            end
        end
        if (byte_in_strobe && pkt_open)
        begin
            acc[byte_idx*8 +: 8] = byte_in;
            byte_idx++;
            byte_cnt++;
            if (byte_idx == 8)
            begin
                push_word(acc, 1'b0);
                acc      = '0;
                byte_idx = 0;
            end
        end
        if (fcs_in_strobe && pkt_open)
        begin
            if (byte_idx != 0)
            begin
                push_word(acc, 1'b0);
            end
            w        = '0;
            w[15:0]  = pkt_len_t'(byte_cnt);
            w[16]    = fcs_ok;
            w[47:32] = rx_sn_t'(accepted);
            push_word(w, 1'b1);
            accepted++;
            pkt_open = 1'b0;
        end
    endtask

    task automatic check_stream();
        stream_word_t ed;
        logic         el;
        if (stall_q && !(m00_axis_tvalid && m00_axis_tdata === held_data &&
                         m00_axis_tlast === held_last))
        begin
            stream_errors++;
            $display("error stall_hold expected %h actual %h", held_data, m00_axis_tdata);
        end
        stall_q   = m00_axis_tvalid && !m00_axis_tready;
        held_data = m00_axis_tdata;
        held_last = m00_axis_tlast;
        if (m00_axis_tvalid && m00_axis_tready)
        begin
            xfer_count++;
            if (m00_axis_tlast)
            begin
                last_seen++;
            end
            if (exp_data.size() == 0)
            begin
                stream_errors++;
                $display("stream word %h arrived when no word was expected", m00_axis_tdata);
            end
            else
            begin
                ed = exp_data.pop_front();
                el = exp_last.pop_front();
                if ({el, ed} !== {m00_axis_tlast, m00_axis_tdata})
                begin
                    stream_errors++;
                    $display("error framing expected %b_%h actual %b_%h",
                             el, ed, m00_axis_tlast, m00_axis_tdata);
                end
            end
        end
    endtask

    task automatic check_totals();
        if (exp_data.size() != 0)
        begin
            count_errors++;
            $display("%0d expected stream words never came out", exp_data.size());
        end
        if (intr_seen != accepted || last_seen != accepted)
        begin
            count_errors++;
            $display("error packet_count expected %0d actual intr %0d tlast %0d",
                     accepted, intr_seen, last_seen);
        end
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            exp_data.delete();
            exp_last.delete();
            exp_strobe    = 1'b0;
            stall_q       = 1'b0;
            pkt_open      = 1'b0;
            words_written = 0;
            xfer_count    = 0;
            drop_model    = 0;
            accepted      = 0;
            intr_seen     = 0;
            last_seen     = 0;
        end
        else
        begin
            check_samples();
            if (dropped_pkts !== rx_sn_t'(drop_model))
            begin
                count_errors++;
                $display("error drop_count expected %0d actual %0d", drop_model, dropped_pkts);
            end
            if (rx_pkt_intr)
            begin
                intr_seen++;
            end
            // decision needs the transfer count from before this edge
            track_packets();
            check_stream();
            if (end_of_test)
            begin
                check_totals();
            end
        end
        pending_words = exp_data.size();
    end

endmodule

/* rx_intf.sv */
// receive interface top with sample select, byte packer, packet framer and stream FIFO
`timescale 1ns/1ps

module rx_intf
    import rx_intf_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  rx_cfg_t      cfg,
    input  ant_pair_t    adc_data,
    input  logic         adc_valid,
    input  iq_sample_t   iq0_from_tx_intf,
    input  iq_sample_t   iq1_from_tx_intf,
    input  logic         iq_valid_from_tx_intf,
    output iq_sample_t   sample0,
    output iq_sample_t   sample1,
    output logic         sample_strobe,
    input  pkt_hdr_t     pkt_hdr,
    input  logic         pkt_header_valid,
    input  logic         pkt_header_valid_strobe,
    input  logic [7:0]   byte_in,
    input  logic         byte_in_strobe,
    input  logic         fcs_in_strobe,
    input  logic         fcs_ok,
    input  logic         m00_axis_tready,
    output logic         m00_axis_tvalid,
    output stream_word_t m00_axis_tdata,
    output logic         m00_axis_tlast,
    output logic         rx_pkt_intr,
    output rx_sn_t       dropped_pkts
);

    // packer and framer
    logic         pkt_clear;
    stream_word_t word;
    logic         word_strobe;
    logic         pkt_end;
    pkt_len_t     bytes_seen;

    // framer and FIFO
    stream_word_t wr_word;
    logic         wr_last;
    logic         wr_en;
    fifo_level_t  free_words;

    rx_sample_sel rx_sample_sel_i (
        .clk                   (clk),
        .reset                 (reset),
        .cfg                   (cfg),
        .adc_data              (adc_data),
        .adc_valid             (adc_valid),
        .iq0_from_tx_intf      (iq0_from_tx_intf),
        .iq1_from_tx_intf      (iq1_from_tx_intf),
        .iq_valid_from_tx_intf (iq_valid_from_tx_intf),
        .sample0               (sample0),
        .sample1               (sample1),
        .sample_strobe         (sample_strobe)
    );

    byte_to_word_packer byte_to_word_packer_i (
        .clk            (clk),
        .reset          (reset),
        .pkt_clear      (pkt_clear),
        .byte_in        (byte_in),
        .byte_in_strobe (byte_in_strobe),
        .fcs_in_strobe  (fcs_in_strobe),
        .word           (word),
        .word_strobe    (word_strobe),
        .pkt_end        (pkt_end),
        .bytes_seen     (bytes_seen)
    );

    rx_pkt_framer rx_pkt_framer_i (
        .clk                     (clk),
        .reset                   (reset),
        .pkt_hdr                 (pkt_hdr),
        .pkt_header_valid        (pkt_header_valid),
        .pkt_header_valid_strobe (pkt_header_valid_strobe),
        .fcs_in_strobe           (fcs_in_strobe),
        .fcs_ok                  (fcs_ok),
        .word                    (word),
        .word_strobe             (word_strobe),
        .pkt_end                 (pkt_end),
        .bytes_seen              (bytes_seen),
        .free_words              (free_words),
        .pkt_clear               (pkt_clear),
        .wr_word                 (wr_word),
        .wr_last                 (wr_last),
        .wr_en                   (wr_en),
        .rx_pkt_intr             (rx_pkt_intr),
        .dropped_pkts            (dropped_pkts)
    );

    rx_stream_fifo rx_stream_fifo_i (
        .clk             (clk),
        .reset           (reset),
        .wr_word         (wr_word),
        .wr_last         (wr_last),
        .wr_en           (wr_en),
        .m00_axis_tready (m00_axis_tready),
        .m00_axis_tvalid (m00_axis_tvalid),
        .m00_axis_tdata  (m00_axis_tdata),
        .m00_axis_tlast  (m00_axis_tlast),
        .free_words      (free_words)
    );

endmodule

/* rx_stream_fifo.sv */
// stream word FIFO with last flag, free space count and registered valid/ready output
`timescale 1ns/1ps
`include "rx_intf_settings.svh"

module rx_stream_fifo
    import rx_intf_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  stream_word_t wr_word,
    input  logic         wr_last,
    input  logic         wr_en,
    input  logic         m00_axis_tready,
    output logic         m00_axis_tvalid,
    output stream_word_t m00_axis_tdata,
    output logic         m00_axis_tlast,
    output fifo_level_t  free_words
);

    localparam int ADDR_W = $clog2(`FIFO_DEPTH);

    stream_word_t      mem_data [`FIFO_DEPTH];
    logic              mem_last [`FIFO_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    fifo_level_t       count;
    logic              pop;

    // refill the output register when empty or being taken
    assign pop = (count != '0) & (~m00_axis_tvalid | m00_axis_tready);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            m00_axis_tvalid <= 1'b0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + fifo_level_t'(wr_en) - fifo_level_t'(pop);
            if (pop)
            begin
                m00_axis_tvalid <= 1'b1;
            end
            else if (m00_axis_tready)
            begin
                m00_axis_tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem_data[wr_ptr] <= wr_word;
            mem_last[wr_ptr] <= wr_last;
        end
        if (pop)
        begin
            m00_axis_tdata <= mem_data[rd_ptr];
            m00_axis_tlast <= mem_last[rd_ptr];
        end
    end

    // output register not counted, it only adds slack
    assign free_words = fifo_level_t'(`FIFO_DEPTH) - count;

    property p_hold_under_stall;
        @(posedge clk) disable iff (reset)
            (m00_axis_tvalid && !m00_axis_tready) |=>
                (m00_axis_tvalid && $stable(m00_axis_tdata) && $stable(m00_axis_tlast));
    endproperty
    a_hold_under_stall: assert property (p_hold_under_stall)
        else $error("stream output changed while stalled");

endmodule

/* rx_pkt_framer.sv */
// packet accept/drop FSM, header and trailer words, sequence number and rx interrupt
`timescale 1ns/1ps
`include "rx_intf_settings.svh"

module rx_pkt_framer
    import rx_intf_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  pkt_hdr_t     pkt_hdr,
    input  logic         pkt_header_valid,
    input  logic         pkt_header_valid_strobe,
    input  logic         fcs_in_strobe,
    input  logic         fcs_ok,
    input  stream_word_t word,
    input  logic         word_strobe,
    input  logic         pkt_end,
    input  pkt_len_t     bytes_seen,
    input  fifo_level_t  free_words,
    output logic         pkt_clear,
    output stream_word_t wr_word,
    output logic         wr_last,
    output logic         wr_en,
    output logic         rx_pkt_intr,
    output rx_sn_t       dropped_pkts
);

    localparam int NEED_W = `PKT_LEN_WIDTH + 1;

    framer_state_t     state;
    pkt_hdr_t          hdr_q;
    rx_sn_t            rx_sn;
    logic              fcs_ok_q;
    logic              data_pend;
    stream_word_t      data_q;
    logic              hdr_fire;
    logic              len_ok;
    logic              room_ok;
    logic [NEED_W-1:0] need_words;
    logic              trailer_wr;
    stream_word_t      hdr_word;
    stream_word_t      trl_word;

    assign hdr_fire = pkt_header_valid_strobe & pkt_header_valid;

    // data words rounded up, plus header and trailer
    assign need_words = (({1'b0, pkt_hdr.len} + NEED_W'(7)) >> 3) + NEED_W'(2);
    assign len_ok     = (pkt_hdr.len <= pkt_len_t'(`MAX_PKT_BYTES));
    assign room_ok    = (need_words <= NEED_W'(free_words));

    // packer restarts on every new header seen while idle, kept or not
    assign pkt_clear = hdr_fire & (state == fr_idle);

    assign hdr_word = {16'd0, rx_sn, 4'd0,
                       hdr_q.ht_unsupport, hdr_q.ht_sgi, hdr_q.ht_aggr_last, hdr_q.ht_aggr,
                       hdr_q.rate, hdr_q.len};
    assign trl_word = {16'd0, rx_sn, 15'd0, fcs_ok_q, bytes_seen};

    // a flushed last word goes out before the trailer
    assign trailer_wr  = (state == fr_trailer) & ~data_pend;
    assign wr_en       = data_pend | (state == fr_header) | trailer_wr;
    assign wr_last     = trailer_wr;
    assign rx_pkt_intr = trailer_wr;

    always_comb
    begin
        if (data_pend)
        begin
            wr_word = data_q;
        end
        else if (state == fr_header)
        begin
            wr_word = hdr_word;
        end
        else
        begin
            wr_word = trl_word;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state        <= fr_idle;
            rx_sn        <= '0;
            dropped_pkts <= '0;
            data_pend    <= 1'b0;
        end
        else
        begin
            data_pend <= word_strobe & (state == fr_data);
            case (state)
                fr_idle:
                begin
                    if (hdr_fire)
                    begin
                        if (len_ok && room_ok)
                        begin
                            state <= fr_header;
                        end
                        else
                        begin
                            dropped_pkts <= dropped_pkts + 1'b1;
                        end
                    end
                end
                fr_header:
                begin
                    state <= fr_data;
                end
                fr_data:
                begin
                    if (pkt_end)
                    begin
                        state <= fr_trailer;
                    end
                end
                fr_trailer:
                begin
                    if (!data_pend)
                    begin
                        state <= fr_idle;
                        rx_sn <= rx_sn + 1'b1;
                    end
                end
                default:
                begin
                    state <= fr_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (hdr_fire && state == fr_idle)
        begin
            hdr_q <= pkt_hdr;
        end
        if (fcs_in_strobe)
        begin
            fcs_ok_q <= fcs_ok;
        end
        if (word_strobe)
        begin
            data_q <= word;
        end
    end

    // room reserved at accept must cover every write of the packet
    property p_no_write_when_full;
        @(posedge clk) disable iff (reset) wr_en |-> (free_words != '0);
    endproperty
    a_no_write_when_full: assert property (p_no_write_when_full)
        else $error("framer wrote into a full FIFO");

endmodule

/* byte_to_word_packer.sv */
// byte to 64-bit word packer with partial word flush on the FCS strobe
`timescale 1ns/1ps
`include "rx_intf_settings.svh"

module byte_to_word_packer
    import rx_intf_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         pkt_clear,
    input  logic [7:0]   byte_in,
    input  logic         byte_in_strobe,
    input  logic         fcs_in_strobe,
    output stream_word_t word,
    output logic         word_strobe,
    output logic         pkt_end,
    output pkt_len_t     bytes_seen
);

    localparam int BYTES_PER_WORD = `STREAM_DATA_WIDTH / 8;
    localparam int IDX_W = $clog2(BYTES_PER_WORD);

    logic [IDX_W-1:0] byte_idx;
    logic [IDX_W-1:0] idx_base;
    logic [IDX_W-1:0] idx_next;
    stream_word_t     acc;
    stream_word_t     acc_next;
    pkt_len_t         byte_cnt;
    pkt_len_t         cnt_base;
    logic             word_full;
    logic             flush;

    // a clear in the same cycle as a byte still keeps that byte
    always_comb
    begin
        idx_base  = pkt_clear ? '0 : byte_idx;
        cnt_base  = pkt_clear ? '0 : byte_cnt;
        acc_next  = acc;
        idx_next  = idx_base;
        word_full = 1'b0;
        if (byte_in_strobe)
        begin
            // first byte of a word starts from zero so partial words are padded
            if (idx_base == '0)
            begin
                acc_next = '0;
            end
            acc_next[idx_base*8 +: 8] = byte_in;
            idx_next  = idx_base + 1'b1;
            word_full = (idx_base == IDX_W'(BYTES_PER_WORD - 1));
        end
    end

    // leftover bytes at FCS time
    assign flush = fcs_in_strobe & (idx_next != '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            byte_idx    <= '0;
            byte_cnt    <= '0;
            word_strobe <= 1'b0;
            pkt_end     <= 1'b0;
        end
        else
        begin
            byte_idx    <= fcs_in_strobe ? '0 : idx_next;
            byte_cnt    <= cnt_base + pkt_len_t'(byte_in_strobe);
            word_strobe <= word_full | flush;
            pkt_end     <= fcs_in_strobe;
        end
    end

    always_ff @(posedge clk)
    begin
        acc <= acc_next;
        if (word_full || flush)
        begin
            word <= acc_next;
        end
    end

    assign bytes_seen = byte_cnt;

endmodule

/* rx_sample_sel.sv */
// antenna swap, antenna 0 mute and TX loopback select with registered sample output
`timescale 1ns/1ps

module rx_sample_sel
    import rx_intf_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  rx_cfg_t    cfg,
    input  ant_pair_t  adc_data,
    input  logic       adc_valid,
    input  iq_sample_t iq0_from_tx_intf,
    input  iq_sample_t iq1_from_tx_intf,
    input  logic       iq_valid_from_tx_intf,
    output iq_sample_t sample0,
    output iq_sample_t sample1,
    output logic       sample_strobe
);

    ant_pair_t adc_sel;
    logic      sel_valid;

    // swap first, then mute, ADC path only
    always_comb
    begin
        adc_sel = adc_data;
        if (cfg.ant_swap)
        begin
            adc_sel.ant0 = adc_data.ant1;
            adc_sel.ant1 = adc_data.ant0;
        end
        if (cfg.mute_ant0)
        begin
            adc_sel.ant0 = '0;
        end
    end

    assign sel_valid = cfg.loopback_en ? iq_valid_from_tx_intf : adc_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sample_strobe <= 1'b0;
        end
        else
        begin
            sample_strobe <= sel_valid;
        end
    end

    // samples hold between strobes
    always_ff @(posedge clk)
    begin
        if (sel_valid)
        begin
            if (cfg.loopback_en)
            begin
                sample0 <= iq0_from_tx_intf;
                sample1 <= iq1_from_tx_intf;
            end
            else
            begin
                sample0 <= adc_sel.ant0;
                sample1 <= adc_sel.ant1;
            end
        end
    end

    // strobe to the receiver must be clean once out of reset
    property p_strobe_known;
        @(posedge clk) disable iff (reset) !$isunknown(sample_strobe);
    endproperty
    a_strobe_known: assert property (p_strobe_known)
        else $error("sample_strobe is unknown");

endmodule

/* rx_intf_pkg.sv */
// sample, header and configuration types plus the framer state enum
`include "rx_intf_settings.svh"

package rx_intf_pkg;

    typedef logic [`STREAM_DATA_WIDTH-1:0] stream_word_t;
    typedef logic [`PKT_LEN_WIDTH-1:0]     pkt_len_t;
    typedef logic [`SN_WIDTH-1:0]          rx_sn_t;

    // needs to hold 0 up to the full depth
    typedef logic [$clog2(`FIFO_DEPTH+1)-1:0] fifo_level_t;

    // I in the upper half, Q in the lower half
    typedef struct packed {
        logic [`IQ_DATA_WIDTH-1:0] i;
        logic [`IQ_DATA_WIDTH-1:0] q;
    } iq_sample_t;

    // same packing as the ADC word, antenna 0 in the low bits
    typedef struct packed {
        iq_sample_t ant1;
        iq_sample_t ant0;
    } ant_pair_t;

    // decoder header fields
    typedef struct packed {
        logic [`RATE_WIDTH-1:0] rate;
        pkt_len_t               len;
        logic                   ht_aggr;
        logic                   ht_aggr_last;
        logic                   ht_sgi;
        logic                   ht_unsupport;
    } pkt_hdr_t;

    typedef struct packed {
        logic ant_swap;
        logic mute_ant0;
        logic loopback_en;
    } rx_cfg_t;

    typedef enum logic [1:0] {
        fr_idle,
        fr_header,
        fr_data,
        fr_trailer
    } framer_state_t;

endpackage

/* rx_intf_settings.svh */
// width, FIFO depth and packet length macros for the receive interface
`ifndef RX_INTF_SETTINGS_SVH
`define RX_INTF_SETTINGS_SVH

// one I or Q component of an ADC sample
`define IQ_DATA_WIDTH 16

// word on the output stream
`define STREAM_DATA_WIDTH 64

// stream FIFO size in words
`define FIFO_DEPTH 64

// longest packet the framer accepts, in bytes
`define MAX_PKT_BYTES 256

// header field widths
`define PKT_LEN_WIDTH 16
`define RATE_WIDTH 8
`define SN_WIDTH 16

`endif
